// File: hdl/rt_geom_pkg.sv
`default_nettype none

package rt_geom_pkg;

  localparam int coord_w = 12;
  localparam int edge_w  = coord_w + 1;     // difference of two coordinates
  localparam int cross_w = 2 * edge_w + 1;  // difference of two edge products
  localparam int dot_w   = 41;              // sum of three edge*cross products

  typedef struct packed {
    logic signed [coord_w-1:0] x;
    logic signed [coord_w-1:0] y;
    logic signed [coord_w-1:0] z;
  } vec3_t;

  typedef struct packed {
    logic signed [cross_w-1:0] x;
    logic signed [cross_w-1:0] y;
    logic signed [cross_w-1:0] z;
  } cvec_t;

  typedef struct packed {
    vec3_t orig;
    vec3_t dir;
  } ray_t;

  typedef struct packed {
    vec3_t       v0;
    vec3_t       v1;
    vec3_t       v2;
    logic [31:0] sid;  // surface id
  } triangle_t;

  // t = t_num / det, det is positive whenever hit is set
  typedef struct packed {
    logic                    hit;
    logic [31:0]             sid;
    logic signed [dot_w-1:0] t_num;
    logic signed [dot_w-1:0] det;
    cvec_t                   normal;  // e1 x e2, not normalized
  } hit_result_t;

endpackage

`default_nettype wire

// File: hdl/rt_ctrl_pkg.sv
`default_nettype none

package rt_ctrl_pkg;

  localparam int thread_w   = 5;
  localparam int tri_idx_w  = 9;   // up to 512 triangles
  localparam int calc_lat   = 4;   // intersect_calc pipeline depth
  localparam int inflight_w = 3;   // holds calc_lat + 1

  typedef enum logic [1:0] {
    idle,
    fetch,
    drain
  } core_state_t;

endpackage

`default_nettype wire

// File: hdl/tri_manager.sv
`timescale 1ns/1ns
`default_nettype none

module tri_manager (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              fetch_start,
  input  logic                              mem_rdy,
  input  logic                              mem_not_valid,
  input  rt_geom_pkg::triangle_t            mem_tri,
  output logic                              mem_en,
  output logic [rt_ctrl_pkg::tri_idx_w-1:0] triangle_id,
  output logic                              tri_valid,
  output rt_geom_pkg::triangle_t            tri_out,
  output logic                              list_end
);

  import rt_ctrl_pkg::*;

  logic waiting;  // read sent, reply not yet seen
  logic got_tri;
  logic got_end;

  assign got_tri = mem_rdy && waiting;
  assign got_end = mem_not_valid && waiting;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_en      <= 1'b0;
      waiting     <= 1'b0;
      tri_valid   <= 1'b0;
      list_end    <= 1'b0;
      triangle_id <= '0;
    end else begin
      mem_en    <= fetch_start || got_tri;  // next read goes out with tri_valid
      waiting   <= mem_en || (waiting && !mem_rdy && !mem_not_valid);
      tri_valid <= got_tri;
      list_end  <= got_end;
      if (fetch_start) begin
        triangle_id <= '0;
      end else if (got_tri) begin
        triangle_id <= triangle_id + tri_idx_w'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (got_tri) begin
      tri_out <= mem_tri;
    end
  end

  // only one read may be open towards the memory
  a_one_outstanding : assert property (
    @(posedge clk) disable iff (rst)
    mem_en |-> !waiting
  );

  a_reply_exclusive : assert property (
    @(posedge clk) disable iff (rst)
    !(mem_rdy && mem_not_valid)
  );

endmodule

`default_nettype wire

// File: hdl/intersect_calc.sv
`timescale 1ns/1ns
`default_nettype none

module intersect_calc (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  rt_geom_pkg::triangle_t   tri_in,
  input  rt_geom_pkg::ray_t        ray,
  output logic                     res_valid,
  output rt_geom_pkg::hit_result_t res
);

  import rt_geom_pkg::*;
  import rt_ctrl_pkg::*;

  typedef struct packed {
    logic signed [edge_w-1:0] x;
    logic signed [edge_w-1:0] y;
    logic signed [edge_w-1:0] z;
  } evec_t;

  typedef struct packed {
    logic [31:0] sid;
    evec_t       e1;
    evec_t       e2;
    evec_t       s;
  } s1_t;

  typedef struct packed {
    logic [31:0] sid;
    evec_t       e1;
    evec_t       e2;
    evec_t       s;
    cvec_t       p;
    cvec_t       q;
    cvec_t       normal;
  } s2_t;

  typedef struct packed {
    logic [31:0]             sid;
    logic signed [dot_w-1:0] det;
    logic signed [dot_w-1:0] u;
    logic signed [dot_w-1:0] v;
    logic signed [dot_w-1:0] t_num;
    cvec_t                   normal;
  } s3_t;

  function automatic evec_t vsub(input vec3_t a, input vec3_t b);
    evec_t d;
    d.x = edge_w'(a.x) - edge_w'(b.x);
    d.y = edge_w'(a.y) - edge_w'(b.y);
    d.z = edge_w'(a.z) - edge_w'(b.z);
    return d;
  endfunction

  function automatic cvec_t cross3(input evec_t a, input evec_t b);
    cvec_t c;
    c.x = cross_w'(a.y) * cross_w'(b.z) - cross_w'(a.z) * cross_w'(b.y);
    c.y = cross_w'(a.z) * cross_w'(b.x) - cross_w'(a.x) * cross_w'(b.z);
    c.z = cross_w'(a.x) * cross_w'(b.y) - cross_w'(a.y) * cross_w'(b.x);
    return c;
  endfunction

  function automatic logic signed [dot_w-1:0] dot3(input evec_t a, input cvec_t b);
    return dot_w'(a.x) * dot_w'(b.x) + dot_w'(a.y) * dot_w'(b.y)
         + dot_w'(a.z) * dot_w'(b.z);
  endfunction

  logic [calc_lat-1:0]   vld;  // one valid bit per stage
  s1_t                   s1;
  s2_t                   s2;
  s3_t                   s3;
  evec_t                 dir_e;
  logic signed [dot_w:0] uv_sum;
  logic                  hit_s4;

  assign dir_e  = vsub(ray.dir, '0);  // widen to edge width
  assign uv_sum = (dot_w+1)'(s3.u) + (dot_w+1)'(s3.v);

  // back faces and parallel rays fail on det
  assign hit_s4 = !s3.det[dot_w-1] && (s3.det != '0)
                && !s3.u[dot_w-1] && !s3.v[dot_w-1]
                && (uv_sum <= (dot_w+1)'(s3.det))
                && !s3.t_num[dot_w-1] && (s3.t_num != '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld <= '0;
    end else begin
      vld <= {vld[calc_lat-2:0], in_valid};
    end
  end

  assign res_valid = vld[calc_lat-1];

  always_ff @(posedge clk) begin
    s1.sid <= tri_in.sid;
    s1.e1  <= vsub(tri_in.v1, tri_in.v0);
    s1.e2  <= vsub(tri_in.v2, tri_in.v0);
    s1.s   <= vsub(ray.orig, tri_in.v0);

    s2.sid    <= s1.sid;
    s2.e1     <= s1.e1;
    s2.e2     <= s1.e2;
    s2.s      <= s1.s;
    s2.p      <= cross3(dir_e, s1.e2);
    s2.q      <= cross3(s1.s, s1.e1);
    s2.normal <= cross3(s1.e1, s1.e2);

    s3.sid    <= s2.sid;
    s3.det    <= dot3(s2.e1, s2.p);
    s3.u      <= dot3(s2.s, s2.p);
    s3.v      <= dot3(dir_e, s2.q);
    s3.t_num  <= dot3(s2.e2, s2.q);
    s3.normal <= s2.normal;

    res.hit    <= hit_s4;
    res.sid    <= s3.sid;
    res.t_num  <= s3.t_num;
    res.det    <= s3.det;
    res.normal <= s3.normal;
  end

  // the ray is read again in later stages, so it must hold while a triangle is inside
  a_fixed_latency : assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> ##calc_lat (res_valid && (ray == $past(ray, calc_lat)))
  );

endmodule

`default_nettype wire

// File: hdl/closest_hit.sv
`timescale 1ns/1ns
`default_nettype none

module closest_hit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic                     res_valid,
  input  rt_geom_pkg::hit_result_t res,
  output rt_geom_pkg::hit_result_t best
);

  import rt_geom_pkg::*;

  localparam int prod_w = 2 * dot_w;

  logic signed [prod_w-1:0] new_scaled;  // res.t_num * best.det
  logic signed [prod_w-1:0] old_scaled;  // best.t_num * res.det
  logic                     nearer;
  logic                     take;

  // both denominators are positive, so cross multiplying keeps the order
  assign new_scaled = prod_w'(res.t_num) * prod_w'(best.det);
  assign old_scaled = prod_w'(best.t_num) * prod_w'(res.det);

  assign nearer = !best.hit || (new_scaled < old_scaled);  // tie keeps earlier
  assign take   = res_valid && res.hit && nearer;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      best <= '0;
    end else if (clear) begin
      best <= '0;
    end else if (take) begin
      best <= res;
    end
  end

  a_hit_has_det : assert property (
    @(posedge clk) disable iff (rst)
    best.hit |-> (!best.det[dot_w-1] && (best.det != '0))
  );

endmodule

`default_nettype wire

// File: hdl/intersect_core.sv
`timescale 1ns/1ns
`default_nettype none

module intersect_core (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  logic [rt_ctrl_pkg::thread_w-1:0]  thread_id_in,
  input  rt_geom_pkg::ray_t                 ray,
  output logic                              ready,
  output logic                              done,
  output logic [rt_ctrl_pkg::thread_w-1:0]  thread_id_out,
  output rt_geom_pkg::hit_result_t          result,
  output logic                              mem_en,
  output logic [rt_ctrl_pkg::tri_idx_w-1:0] triangle_id,
  input  logic                              mem_rdy,
  input  logic                              mem_not_valid,
  input  rt_geom_pkg::triangle_t            mem_tri
);

  import rt_geom_pkg::*;
  import rt_ctrl_pkg::*;

  core_state_t           state;
  core_state_t           state_nxt;
  ray_t                  ray_q;
  logic [thread_w-1:0]   thread_q;
  logic [inflight_w-1:0] inflight;  // triangles inside intersect_calc
  logic                  launch;
  logic                  tri_valid;
  logic                  list_end;
  logic                  res_valid;
  triangle_t             tri_q;
  hit_result_t           calc_res;

  assign ready  = (state == idle);
  assign launch = start && ready;
  assign done   = (state == drain) && (inflight == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      idle:    if (launch) state_nxt = fetch;
      fetch:   if (list_end) state_nxt = drain;
      drain:   if (done) state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      inflight <= '0;
    end else begin
      case ({tri_valid, res_valid})
        2'b10:   inflight <= inflight + inflight_w'(1);
        2'b01:   inflight <= inflight - inflight_w'(1);
        default: inflight <= inflight;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      ray_q    <= ray;
      thread_q <= thread_id_in;
    end
  end

  assign thread_id_out = thread_q;

  tri_manager tri_manager_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_start  (launch),
    .mem_rdy      (mem_rdy),
    .mem_not_valid(mem_not_valid),
    .mem_tri      (mem_tri),
    .mem_en       (mem_en),
    .triangle_id  (triangle_id),
    .tri_valid    (tri_valid),
    .tri_out      (tri_q),
    .list_end     (list_end)
  );

  intersect_calc intersect_calc_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (tri_valid),
    .tri_in   (tri_q),
    .ray      (ray_q),
    .res_valid(res_valid),
    .res      (calc_res)
  );

  closest_hit closest_hit_i (
    .clk      (clk),
    .rst      (rst),
    .clear    (launch),
    .res_valid(res_valid),
    .res      (calc_res),
    .best     (result)
  );

  a_start_when_ready : assert property (
    @(posedge clk) disable iff (rst)
    start |-> ready
  );

endmodule

`default_nettype wire

// File: verif/tb_tri_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tri_mem (
  input  logic                              clk,
  input  logic                              rst,
  input  rt_geom_pkg::triangle_t [3:0]      tri_list,
  input  logic [2:0]                        tri_count,
  input  logic                              mem_en,
  input  logic [rt_ctrl_pkg::tri_idx_w-1:0] triangle_id,
  output logic                              mem_rdy,
  output logic                              mem_not_valid,
  output rt_geom_pkg::triangle_t            mem_tri,
  output logic                              proto_err
);

  import rt_ctrl_pkg::*;

  logic                 pending;
  int unsigned          wait_left;
  logic [tri_idx_w-1:0] req_id;
  logic [tri_idx_w-1:0] next_id;  // index the core should ask for next

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      pending = 1'b0;
      wait_left = 0;
      req_id = '0;
      next_id = '0;
      mem_rdy       <= 1'b0;
      mem_not_valid <= 1'b0;
      mem_tri       <= '0;
      proto_err     <= 1'b0;
    end else begin
      mem_rdy       <= 1'b0;
      mem_not_valid <= 1'b0;
      if (mem_en) begin
        if (pending) begin
          $display("memory: read at %0t while the previous read is still open", $time);
          proto_err <= 1'b1;
        end
        if (triangle_id != next_id) begin
          $display("memory: read of triangle %0d, but index %0d was due", triangle_id, next_id);
          proto_err <= 1'b1;
        end
        pending = 1'b1;
        wait_left = $urandom % 4;  // reply 1 to 4 cycles after the request
        req_id = triangle_id;
      end else if (pending) begin
        wait_left = wait_left - 1;
      end
      if (pending && wait_left == 0) begin
        pending = 1'b0;
        if (req_id < tri_idx_w'(tri_count)) begin
          mem_rdy <= 1'b1;
          mem_tri <= tri_list[req_id[1:0]];
          next_id = next_id + tri_idx_w'(1);
        end else begin
          mem_not_valid <= 1'b1;  // past the end of the list
          next_id = '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_intersect_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_intersect_core;

  import rt_geom_pkg::*;
  import rt_ctrl_pkg::*;

  typedef struct packed {
    longint x;
    longint y;
    longint z;
  } lvec_t;

  typedef struct packed {
    ray_t                ray;
    logic [thread_w-1:0] thread_id;
    logic [2:0]          count;
    triangle_t [3:0]     tris;   // index 0 is fetched first
    logic                hit;
    logic [31:0]         sid;    // expected winner
  } test_row_t;

  localparam int n_rows      = 9;
  localparam int cycle_limit = n_rows * (4 * 6 + calc_lat + 10) + 10;  // extra for reset

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic                 ready;
  logic                 done;
  logic [thread_w-1:0]  thread_id_in;
  logic [thread_w-1:0]  thread_id_out;
  ray_t                 ray;
  hit_result_t          result;
  logic                 mem_en;
  logic [tri_idx_w-1:0] triangle_id;
  logic                 mem_rdy;
  logic                 mem_not_valid;
  triangle_t            mem_tri;
  triangle_t [3:0]      tri_list;
  logic [2:0]           tri_count;
  logic                 proto_err;
  test_row_t            rows [n_rows];
  int                   cycles;

  intersect_core intersect_core_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .thread_id_in (thread_id_in),
    .ray          (ray),
    .ready        (ready),
    .done         (done),
    .thread_id_out(thread_id_out),
    .result       (result),
    .mem_en       (mem_en),
    .triangle_id  (triangle_id),
    .mem_rdy      (mem_rdy),
    .mem_not_valid(mem_not_valid),
    .mem_tri      (mem_tri)
  );

  tb_tri_mem tri_mem_i (
    .clk          (clk),
    .rst          (rst),
    .tri_list     (tri_list),
    .tri_count    (tri_count),
    .mem_en       (mem_en),
    .triangle_id  (triangle_id),
    .mem_rdy      (mem_rdy),
    .mem_not_valid(mem_not_valid),
    .mem_tri      (mem_tri),
    .proto_err    (proto_err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic vec3_t pt(input int x, input int y, input int z);
    vec3_t p;
    p.x = coord_w'(x);
    p.y = coord_w'(y);
    p.z = coord_w'(z);
    return p;
  endfunction

  function automatic ray_t make_ray(input vec3_t orig, input vec3_t dir);
    ray_t r;
    r.orig = orig;
    r.dir  = dir;
    return r;
  endfunction

  function automatic triangle_t facet(input vec3_t a, b, c, input int unsigned sid);
    triangle_t t;
    t.v0  = a;
    t.v1  = b;
    t.v2  = c;
    t.sid = sid;
    return t;
  endfunction

  // faces +z, covers x >= -h, y >= -h, x + y <= 0 in the plane at z
  function automatic triangle_t plate(input int z, input int h, input int unsigned sid);
    return facet(pt(-h, -h, z), pt(h, -h, z), pt(-h, h, z), sid);
  endfunction

  function automatic triangle_t plate_back(input int z, input int h, input int unsigned sid);
    return facet(pt(-h, -h, z), pt(-h, h, z), pt(h, -h, z), sid);  // winding flipped
  endfunction

  function automatic test_row_t make_row(input ray_t r, input int thread_id, input int count,
                                         input triangle_t t0, t1, t2, t3,
                                         input int hit, input int unsigned sid);
    test_row_t row;
    row.ray       = r;
    row.thread_id = thread_w'(thread_id);
    row.count     = 3'(count);
    row.tris      = {t3, t2, t1, t0};
    row.hit       = hit[0];
    row.sid       = sid;
    return row;
  endfunction

  function automatic lvec_t widen(input vec3_t a);
    lvec_t w;
    w.x = longint'(a.x);
    w.y = longint'(a.y);
    w.z = longint'(a.z);
    return w;
  endfunction

  function automatic lvec_t diff(input lvec_t a, input lvec_t b);
    lvec_t d;
    d.x = a.x - b.x;
    d.y = a.y - b.y;
    d.z = a.z - b.z;
    return d;
  endfunction

  function automatic lvec_t cross_prod(input lvec_t a, input lvec_t b);
    lvec_t c;
    c.x = a.y * b.z - a.z * b.y;
    c.y = a.z * b.x - a.x * b.z;
    c.z = a.x * b.y - a.y * b.x;
    return c;
  endfunction

  function automatic longint dot_prod(input lvec_t a, input lvec_t b);
    return a.x * b.x + a.y * b.y + a.z * b.z;
  endfunction

  // culled Moller-Trumbore over the row, nearest hit wins, ties keep the earlier one
  function automatic hit_result_t expected_result(input test_row_t row);
    hit_result_t best;
    lvec_t       d;
    lvec_t       e1;
    lvec_t       e2;
    lvec_t       s;
    lvec_t       p;
    lvec_t       q;
    lvec_t       n;
    longint      det;
    longint      u;
    longint      v;
    longint      t;
    int          i;
    best = '0;
    d = widen(row.ray.dir);
    for (i = 0; i < int'(row.count); i++) begin
      e1  = diff(widen(row.tris[i].v1), widen(row.tris[i].v0));
      e2  = diff(widen(row.tris[i].v2), widen(row.tris[i].v0));
      s   = diff(widen(row.ray.orig), widen(row.tris[i].v0));
      p   = cross_prod(d, e2);
      q   = cross_prod(s, e1);
      n   = cross_prod(e1, e2);
      det = dot_prod(e1, p);
      u   = dot_prod(s, p);
      v   = dot_prod(d, q);
      t   = dot_prod(e2, q);
      if (det > 0 && u >= 0 && v >= 0 && u + v <= det && t > 0 &&
          (!best.hit || t * best.det < best.t_num * det)) begin
        best.hit      = 1'b1;
        best.sid      = row.tris[i].sid;
        best.t_num    = dot_w'(t);
        best.det      = dot_w'(det);
        best.normal.x = cross_w'(n.x);
        best.normal.y = cross_w'(n.y);
        best.normal.z = cross_w'(n.z);
      end
    end
    return best;
  endfunction

  task automatic compare_values(input logic [127:0] got, input logic [127:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic fill_table();
    ray_t      down;
    ray_t      side;
    ray_t      slant;
    triangle_t none;
    down  = make_ray(pt(-5, -5, 5), pt(0, 0, -1));
    side  = make_ray(pt(-5, -5, 5), pt(1, 0, 0));     // parallel to the plates
    slant = make_ray(pt(-6, -6, 10), pt(1, 1, -4));
    none  = '0;
    rows[0] = make_row(down, 3, 1, plate(0, 10, 11), none, none, none, 1, 11);
    rows[1] = make_row(down, 7, 1, facet(pt(0, 0, 0), pt(20, 0, 0), pt(0, 20, 0), 21),
                       none, none, none, 0, 0);       // outside an edge
    rows[2] = make_row(side, 9, 1, plate(0, 10, 22), none, none, none, 0, 0);
    rows[3] = make_row(down, 12, 1, plate_back(0, 10, 23), none, none, none, 0, 0);
    rows[4] = make_row(down, 14, 2, plate(8, 10, 24), plate(5, 10, 25), none, none, 0, 0);
    rows[5] = make_row(down, 17, 4, plate(-20, 10, 51), plate(2, 10, 52),
                       plate(-3, 10, 53), plate(8, 10, 54), 1, 52);
    rows[6] = make_row(down, 20, 4, plate(1, 10, 61), plate_back(3, 10, 62),
                       plate(1, 20, 63), plate(-4, 10, 64), 1, 61);  // tie with other det
    rows[7] = make_row(down, 31, 0, none, none, none, none, 0, 0);
    rows[8] = make_row(slant, 0, 3, plate(-10, 10, 81), plate(-5, 10, 82),
                       plate(4, 10, 83), none, 1, 83);
  endtask

  task automatic run_row(input int i);
    test_row_t   row;
    hit_result_t exp;
    row = rows[i];
    exp = expected_result(row);
    @(negedge clk);
    compare_values(ready, 1, $sformatf("row %0d ready before start", i));
    tri_list     = row.tris;
    tri_count    = row.count;
    ray          = row.ray;
    thread_id_in = row.thread_id;
    start        = 1'b1;
    @(negedge clk);
    start        = 1'b0;
    ray          = '1;                // captured at start, must not matter now
    thread_id_in = ~row.thread_id;
    while (!done) @(negedge clk);
    compare_values(exp.sid, row.sid, $sformatf("row %0d reference winner", i));
    compare_values(result.hit, row.hit, $sformatf("row %0d hit", i));
    compare_values(result.sid, row.sid, $sformatf("row %0d sid", i));
    compare_values(result.t_num, exp.t_num, $sformatf("row %0d t_num", i));
    compare_values(result.det, exp.det, $sformatf("row %0d det", i));
    compare_values(result.normal, exp.normal, $sformatf("row %0d normal", i));
    compare_values(thread_id_out, row.thread_id, $sformatf("row %0d thread id", i));
  endtask

  initial begin
    void'($urandom(32'h5a57_a05c));
    rst          = 1'b1;
    start        = 1'b0;
    thread_id_in = '0;
    ray          = '0;
    tri_list     = '0;
    tri_count    = '0;
    fill_table();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    @(negedge clk);
    $display("Test OK");
    $finish;
  end

  initial begin
    @(posedge proto_err);
    $display("the memory model saw a read request out of order or while one was open");
    $display("Test FAILED");
    $fatal(1, "memory protocol error");
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout: the core never finished, %0d cycles passed", cycle_limit);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/rt_geom_pkg.sv
hdl/rt_ctrl_pkg.sv
hdl/tri_manager.sv
hdl/intersect_calc.sv
hdl/closest_hit.sv
hdl/intersect_core.sv
verif/tb_tri_mem.sv
verif/tb_intersect_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the intersection core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_intersect_core

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation passed"
exit 0
